// File: dv/router_tests.svh
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

// quiet outputs after reset and then one local flit goes through
task automatic test_reset_idle();
   int t_in;
   test_name = "reset_idle";
   repeat (5) begin
      @(negedge clk);
      check_vec('0, out_valid);
      check_vec('0, in_credit);
   end
   send_flit(port_local, make_flit(port_local, 1'b0, node_x, node_y), t_in);
   wait_drain();
   check_count(1, out_count[port_local]);
endtask

// every mesh node from the local port one at a time
task automatic test_all_dests();
   int    t_in;
   flit_t f;
   test_name = "all_dests";
   for (int dx = 0; dx < mesh_x_nodes; dx++) begin
      for (int dy = 0; dy < mesh_y_nodes; dy++) begin
         f = make_flit(port_local, dy[0], coord_t'(dx), coord_t'(dy));
         send_flit(port_local, f, t_in);
         wait_drain();
         // fifo, route, output register
         check_count(3, last_out_cycle - t_in);
      end
   end
endtask

// all five inputs at once with random destinations
task automatic test_random_traffic();
   logic [31:0] r;
   test_name = "random_traffic";
   // stimulus built up front so the sequence is fixed
   for (int p = 0; p < num_ports; p++) begin
      for (int i = 0; i < stream_len; i++) begin
         r = next_random();
         stim[p][i] = make_flit(port_t'(p), i[0], r[17:16], r[25:24]);
      end
   end
   fork
      drive_stream(port_local, stream_len);
      drive_stream(port_east, stream_len);
      drive_stream(port_west, stream_len);
      drive_stream(port_south, stream_len);
      drive_stream(port_north, stream_len);
   join
   wait_drain();
endtask

// east link stalls with no credits coming back
task automatic test_back_pressure();
   int t_in;
   int base;
   test_name = "back_pressure";
   // let earlier credits settle first
   repeat (5) @(negedge clk);
   base = out_count[port_east];
   hold[port_east] = 1'b1;
   for (int i = 0; i < 2*buffer_depth; i++) begin
      send_flit(port_local, make_flit(port_local, i[0], 2'd3, coord_t'(i)), t_in);
   end
   repeat (30) @(negedge clk);
   check_count(buffer_depth, out_count[port_east] - base);
   hold[port_east] = 1'b0;
   // scoreboard checks the order of the remaining flits
   wait_drain();
   check_count(2*buffer_depth, out_count[port_east] - base);
endtask

// local and north both aim at east
task automatic test_round_robin();
   test_name = "round_robin";
   repeat (5) @(negedge clk);
   east_order.delete();
   for (int i = 0; i < rr_flits; i++) begin
      stim[port_local][i] = make_flit(port_local, i[0], 2'd2, 2'd1);
      stim[port_north][i] = make_flit(port_north, i[0], 2'd2, 2'd1);
   end
   // held credits keep both inputs backed up
   hold[port_east] = 1'b1;
   fork
      drive_stream(port_local, rr_flits);
      drive_stream(port_north, rr_flits);
   join
   hold[port_east] = 1'b0;
   wait_drain();
   check_count(2*rr_flits, east_order.size());
   for (int i = 1; i < east_order.size(); i++) begin
      check_port((east_order[i-1] == port_local) ? port_north : port_local, east_order[i]);
   end
endtask

// every accepted flit gave its credit back
task automatic test_credit_return();
   test_name = "credit_return";
   repeat (10) @(negedge clk);
   for (int p = 0; p < num_ports; p++) begin
      check_count(sent_cnt[p], cred_cnt[p]);
      check_credit(credit_t'(buffer_depth), up_cred[p]);
   end
endtask

`endif

// File: dv/router_tb.sv
`timescale 1ns/1ns
`default_nettype none

module router_tb import noc_pkg::*, router_pkg::*; ();

   // node under test sits at (1,0)
   localparam coord_t node_x = 2'd1;
   localparam coord_t node_y = 2'd0;
   // roughly four times the summed test length
   localparam int timeout_cycles = 2000;
   localparam int drain_limit = 200;
   localparam int stream_len = 16;
   localparam int rr_flits = buffer_depth + 2;

   logic      clk;
   logic      rst_n;
   flit_t     in_flit [num_ports];
   port_vec_t in_valid;
   port_vec_t in_credit;
   flit_t     out_flit [num_ports];
   port_vec_t out_valid;
   port_vec_t out_credit;

   // one upstream credit counter per input
   credit_t   up_cred [num_ports];
   int        sent_cnt [num_ports];
   int        cred_cnt [num_ports];
   // downstream side
   int        out_count [num_ports];
   int        owed [num_ports];
   port_vec_t hold;
   // expected flits keyed by source * num_ports + output
   flit_t     sb [num_ports*num_ports][$];
   int        pending;
   int        cycles;
   int        last_out_cycle;
   port_t     east_order [$];
   flit_t     stim [num_ports][stream_len];
   logic [31:0] lcg_state;
   string     test_name;

   router_top #(.node_x(node_x), .node_y(node_y)) UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_flit    (in_flit),
      .in_valid   (in_valid),
      .in_credit  (in_credit),
      .out_flit   (out_flit),
      .out_valid  (out_valid),
      .out_credit (out_credit)
   );

   // 10 ns period
   initial clk = 1'b0;
   always #5 clk = ~clk;

   //////////////////////////////
   // helpers
   //////////////////////////////

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // x first, then y, then eject
   function automatic port_t xy_port(input flit_t f);
      if (f.dest_x != node_x) return (f.dest_x > node_x) ? port_east : port_west;
      if (f.dest_y != node_y) return (f.dest_y > node_y) ? port_south : port_north;
      return port_local;
   endfunction

   // seq bit on top of the tag with the source port below
   function automatic flit_t make_flit(input port_t src, input logic seq,
                                       input coord_t dx, input coord_t dy);
      flit_t f;
      f.tag    = tag_t'({seq, src});
      f.dest_x = dx;
      f.dest_y = dy;
      return f;
   endfunction

   task automatic check_flit(input flit_t exp, input flit_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("Fail %s: flit expected %h, actual %h", test_name, exp, act));
      end
   endtask

   task automatic check_port(input port_t exp, input port_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("Fail %s: port expected %0d, actual %0d",
                                 test_name, exp, act));
      end
   endtask

   task automatic check_credit(input credit_t exp, input credit_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("Fail %s: credits expected %0d, actual %0d",
                                 test_name, exp, act));
      end
   endtask

   task automatic check_vec(input port_vec_t exp, input port_vec_t act);
      if (act !== exp) begin
         stop_on_error($sformatf("Fail %s: vector expected %b, actual %b", test_name, exp, act));
      end
   endtask

   task automatic check_count(input int exp, input int act);
      if (act != exp) begin
         stop_on_error($sformatf("Fail %s: count expected %0d, actual %0d",
                                 test_name, exp, act));
      end
   endtask

   // called and returns at a falling edge
   // t_in is the rising edge that samples the flit
   task automatic send_flit(input port_t p, input flit_t f, output int t_in);
      while (up_cred[p] == '0) begin
         @(negedge clk);
      end
      in_flit[p]  = f;
      in_valid[p] = 1'b1;
      sb[int'(f.tag[2:0]) * num_ports + int'(xy_port(f))].push_back(f);
      pending++;
      sent_cnt[p]++;
      t_in = cycles + 1;
      @(negedge clk);
      in_valid[p] = 1'b0;
   endtask

   task automatic drive_stream(input port_t p, input int n);
      int t_in;
      for (int i = 0; i < n; i++) begin
         send_flit(p, stim[p][i], t_in);
      end
   endtask

   // bounded wait for the scoreboard to empty
   task automatic wait_drain();
      int waited;
      waited = 0;
      while (pending != 0 && waited < drain_limit) begin
         @(negedge clk);
         waited++;
      end
      if (pending != 0) begin
         stop_on_error($sformatf("%s: %0d flits were lost inside the router",
                                 test_name, pending));
      end
   endtask

   //////////////////////////////
   // link models
   //////////////////////////////

   // cycle count, timeout, upstream credit bookkeeping
   always @(posedge clk) begin
      cycles++;
      if (cycles >= timeout_cycles) begin
         stop_on_error("cycle limit reached before the tests finished");
      end
      if (rst_n) begin
         for (int p = 0; p < num_ports; p++) begin
            up_cred[p]  = up_cred[p] + credit_t'(in_credit[p]) - credit_t'(in_valid[p]);
            cred_cnt[p] = cred_cnt[p] + int'(in_credit[p]);
         end
      end
   end

   // downstream returns a credit one cycle after each flit unless held
   always @(negedge clk) begin
      for (int p = 0; p < num_ports; p++) begin
         if (!hold[p] && owed[p] > 0) begin
            out_credit[p] = 1'b1;
            owed[p]--;
         end else begin
            out_credit[p] = 1'b0;
         end
         if (rst_n && out_valid[p] === 1'b1) begin
            owed[p]++;
         end
      end
   end

   // output monitor and scoreboard
   always @(negedge clk) begin
      flit_t f;
      flit_t exp;
      int    key;
      if (rst_n) begin
         for (int o = 0; o < num_ports; o++) begin
            if (out_valid[o] === 1'b1) begin
               f = out_flit[o];
               check_port(xy_port(f), port_t'(o));
               key = int'(f.tag[2:0]) * num_ports + o;
               if (f.tag[2:0] >= 3'(num_ports) || sb[key].size() == 0) begin
                  stop_on_error("a flit left the router that was never sent or left twice");
               end
               exp = sb[key].pop_front();
               check_flit(exp, f);
               pending--;
               out_count[o]++;
               // edge where downstream samples it
               last_out_cycle = cycles + 1;
               if (o == int'(port_east)) begin
                  east_order.push_back(port_t'(f.tag[2:0]));
               end
            end
         end
      end
   end

`include "router_tests.svh"

   //////////////////////////////
   // main sequence
   //////////////////////////////
   initial begin
      rst_n       = 1'b0;
      in_valid    = '0;
      out_credit  = '0;
      hold        = '0;
      pending     = 0;
      cycles      = 0;
      lcg_state   = 32'd76;
      test_name   = "reset";
      for (int p = 0; p < num_ports; p++) begin
         in_flit[p]   = '0;
         up_cred[p]   = credit_t'(buffer_depth);
         sent_cnt[p]  = 0;
         cred_cnt[p]  = 0;
         out_count[p] = 0;
         owed[p]      = 0;
      end
      // two rising edges in reset
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      test_reset_idle();
      test_all_dests();
      test_random_traffic();
      test_back_pressure();
      test_round_robin();
      test_credit_return();

      $display("test passed");
      $finish;
   end

endmodule : router_tb

`default_nettype wire

// File: flist.f
+incdir+dv
source/noc_pkg.sv
source/router_pkg.sv
source/input_fifo.sv
source/route_compute.sv
source/switch_alloc.sv
source/output_port.sv
source/router_top.sv
dv/router_tb.sv

// File: source/input_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module input_fifo import noc_pkg::*, router_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire flit_t in_flit,
   input  wire logic  in_valid,
   input  wire logic  pop,
   output flit_t      head_flit,
   output logic       head_valid,
   output logic       credit_ret
);

   // slot index into the ring
   typedef logic [$clog2(buffer_depth)-1:0] ptr_t;

   flit_t   mem [buffer_depth];
   ptr_t    wr_ptr;
   ptr_t    rd_ptr;
   credit_t count;   // occupied slots
   logic    rd;

   // pop only counts when there is a head to take
   assign rd = pop & head_valid;

   // head is always the oldest entry
   assign head_flit  = mem[rd_ptr];
   assign head_valid = (count != '0);

   // storage, no reset on payload
   always_ff @(posedge clk) begin
      if (in_valid) begin
         mem[wr_ptr] <= in_flit;
      end
   end

   //////////////////////////////
   // pointers, count, credit
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_ret <= 1'b0;
      end else begin
         // explicit wrap so any depth works
         if (in_valid) begin
            wr_ptr <= (wr_ptr == ptr_t'(buffer_depth-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= (rd_ptr == ptr_t'(buffer_depth-1)) ? '0 : rd_ptr + 1'b1;
         end
         // write and read together leave count alone
         case ({in_valid, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // freed slot goes back upstream next cycle
         credit_ret <= rd;
      end
   end

endmodule : input_fifo

`default_nettype wire

// File: source/noc_pkg.sv
`default_nettype none

package noc_pkg;

   //////////////////////////////
   // mesh geometry
   //////////////////////////////

   // 4x4 mesh, x grows east and y grows south
   localparam int mesh_x_nodes = 4;
   localparam int mesh_y_nodes = 4;

   // one coordinate wide enough for the larger axis
   localparam int coord_width =
      $clog2((mesh_x_nodes > mesh_y_nodes) ? mesh_x_nodes : mesh_y_nodes);

   // node coordinate
   typedef logic [coord_width-1:0] coord_t;

   //////////////////////////////
   // flit format
   //////////////////////////////

   // payload tag, passed through untouched
   typedef logic [3:0] tag_t;

   // single-flit packet, 8 bits
   // [7:4] tag, [3:2] dest_x, [1:0] dest_y
   typedef struct packed {
      tag_t   tag;
      coord_t dest_x;
      coord_t dest_y;
   } flit_t;

   // input buffer slots per port
   // also the starting credit count on every link
   localparam int buffer_depth = 4;

endpackage : noc_pkg

`default_nettype wire

// File: source/output_port.sv
`timescale 1ns/1ns
`default_nettype none

module output_port import noc_pkg::*, router_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  send,
   input  wire flit_t flit_in,
   input  wire logic  out_credit,
   output logic       has_credit,
   output flit_t      out_flit,
   output logic       out_valid
);

   // free slots left in the downstream fifo
   credit_t credits;

   // allocator may only pick this output with a credit in hand
   assign has_credit = (credits != '0);

   //////////////////////////////
   // output register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         // one-cycle valid per flit sent
         out_valid <= send;
      end
   end

   // flit payload, held between sends
   always_ff @(posedge clk) begin
      if (send) begin
         out_flit <= flit_in;
      end
   end

   //////////////////////////////
   // credit counter
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // downstream starts empty
         credits <= credit_t'(buffer_depth);
      end else begin
         case ({send, out_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            // spend and return together cancel
            default: credits <= credits;
         endcase
      end
   end

endmodule : output_port

`default_nettype wire

// File: source/route_compute.sv
`timescale 1ns/1ns
`default_nettype none

module route_compute import noc_pkg::*, router_pkg::*; #(
   parameter coord_t node_x = 2'd1,
   parameter coord_t node_y = 2'd0
) (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire flit_t head_flit,
   input  wire logic  head_valid,
   input  wire logic  grant,
   output logic       pop,
   output flit_t      flit,
   output port_vec_t  req
);

   logic      valid_q;
   port_vec_t next_req;

   // xy order: settle x first, then y, then eject locally
   function automatic port_vec_t xy_route(input flit_t f);
      port_vec_t r;
      r = '0;
      if (f.dest_x > node_x)      r[port_east]  = 1'b1;
      else if (f.dest_x < node_x) r[port_west]  = 1'b1;
      else if (f.dest_y > node_y) r[port_south] = 1'b1;
      else if (f.dest_y < node_y) r[port_north] = 1'b1;
      else                        r[port_local] = 1'b1;
      return r;
   endfunction

   assign next_req = xy_route(head_flit);

   // take the fifo head when empty or leaving this cycle
   assign pop = head_valid & (~valid_q | grant);

   //////////////////////////////
   // route register
   //////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
         req     <= '0;
      end else if (!valid_q || grant) begin
         valid_q <= head_valid;
         // req drops to zero when nothing loads
         req     <= head_valid ? next_req : '0;
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (pop) begin
         flit <= head_flit;
      end
   end

endmodule : route_compute

`default_nettype wire

// File: source/router_pkg.sv
`default_nettype none

package router_pkg;

   import noc_pkg::*;

   //////////////////////////////
   // port naming
   //////////////////////////////

   // router port ids, also index every per-port array
   typedef enum logic [2:0] {
      port_local = 3'd0,
      port_east  = 3'd1,
      port_west  = 3'd2,
      port_south = 3'd3,
      port_north = 3'd4
   } port_t;

   // local plus four mesh neighbours
   localparam int num_ports = 5;

   // one bit per port, indexed by port_t
   // used for one-hot requests and grants
   typedef logic [num_ports-1:0] port_vec_t;

   //////////////////////////////
   // flow control
   //////////////////////////////

   // credit count, 0 .. buffer_depth inclusive
   typedef logic [$clog2(buffer_depth+1)-1:0] credit_t;

endpackage : router_pkg

`default_nettype wire

// File: source/router_top.sv
`timescale 1ns/1ns
`default_nettype none

module router_top import noc_pkg::*, router_pkg::*; #(
   parameter coord_t node_x = 2'd1,
   parameter coord_t node_y = 2'd0
) (
   input  wire logic      clk,
   input  wire logic      rst_n,
   // upstream side, per input port
   input  wire flit_t     in_flit [num_ports],
   input  wire port_vec_t in_valid,
   output wire port_vec_t in_credit,
   // downstream side, per output port
   output wire flit_t     out_flit [num_ports],
   output wire port_vec_t out_valid,
   input  wire port_vec_t out_credit
);

   // fifo to route stage
   wire flit_t     head_flit [num_ports];
   wire port_vec_t head_valid;
   wire port_vec_t pop;
   // route stage to allocator
   wire flit_t     route_flit [num_ports];
   wire port_vec_t route_req [num_ports];
   wire port_vec_t grant;
   // allocator to outputs
   wire flit_t     xbar_flit [num_ports];
   wire port_vec_t send;
   wire port_vec_t has_credit;

   //////////////////////////////
   // per-port pipeline
   //////////////////////////////
   for (genvar p = 0; p < num_ports; p++) begin : g_port
      // stage 1, input buffer
      input_fifo u_fifo (
         .clk        (clk),
         .rst_n      (rst_n),
         .in_flit    (in_flit[p]),
         .in_valid   (in_valid[p]),
         .pop        (pop[p]),
         .head_flit  (head_flit[p]),
         .head_valid (head_valid[p]),
         .credit_ret (in_credit[p])
      );

      // stage 2, xy decision against this node
      route_compute #(.node_x(node_x), .node_y(node_y)) u_route (
         .clk        (clk),
         .rst_n      (rst_n),
         .head_flit  (head_flit[p]),
         .head_valid (head_valid[p]),
         .grant      (grant[p]),
         .pop        (pop[p]),
         .flit       (route_flit[p]),
         .req        (route_req[p])
      );

      // stage 3, output register and link credits
      output_port u_out (
         .clk        (clk),
         .rst_n      (rst_n),
         .send       (send[p]),
         .flit_in    (xbar_flit[p]),
         .out_credit (out_credit[p]),
         .has_credit (has_credit[p]),
         .out_flit   (out_flit[p]),
         .out_valid  (out_valid[p])
      );
   end

   // shared allocator and crossbar
   switch_alloc u_alloc (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (route_req),
      .flit_in    (route_flit),
      .has_credit (has_credit),
      .grant      (grant),
      .send       (send),
      .flit_out   (xbar_flit)
   );

endmodule : router_top

`default_nettype wire

// File: source/switch_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module switch_alloc import noc_pkg::*, router_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst_n,
   input  wire port_vec_t req [num_ports],      // per input, one-hot output
   input  wire flit_t     flit_in [num_ports],  // per input
   input  wire port_vec_t has_credit,           // per output
   output port_vec_t      grant,                // per input
   output port_vec_t      send,                 // per output
   output flit_t          flit_out [num_ports]  // per output
);

   // round-robin start point, one per output
   port_t ptr [num_ports];
   // winning input, one per output
   port_t win [num_ports];

   //////////////////////////////
   // per-output arbitration
   //////////////////////////////
   always_comb begin
      int idx;
      idx = 0;
      for (int o = 0; o < num_ports; o++) begin
         send[o] = 1'b0;
         win[o]  = port_local;
         // scan inputs from the pointer onward, wrap mod 5
         for (int k = 0; k < num_ports; k++) begin
            idx = (int'(ptr[o]) + k) % num_ports;
            // first requester wins, only if downstream has room
            if (!send[o] && has_credit[o] && req[idx][o]) begin
               send[o] = 1'b1;
               win[o]  = port_t'(idx);
            end
         end
      end
   end

   // each input asks for one output, so at most one grant per input
   always_comb begin
      grant = '0;
      for (int o = 0; o < num_ports; o++) begin
         if (send[o]) begin
            grant[win[o]] = 1'b1;
         end
      end
   end

   //////////////////////////////
   // crossbar
   //////////////////////////////
   always_comb begin
      for (int o = 0; o < num_ports; o++) begin
         // output register only loads when send is high
         flit_out[o] = flit_in[win[o]];
      end
   end

   // priority moves just past the last winner
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int o = 0; o < num_ports; o++) begin
            ptr[o] <= port_local;
         end
      end else begin
         for (int o = 0; o < num_ports; o++) begin
            if (send[o]) begin
               ptr[o] <= port_t'((int'(win[o]) + 1) % num_ports);
            end
         end
      end
   end

endmodule : switch_alloc

`default_nettype wire
